// File: src/cda_pkg.sv
package cda_pkg;

  // ==================================================
  // Region geometry
  // ==================================================

  // Number of clock delay adjusters in one region
  localparam int N_CDA = 4;

  // Width of one CDA delay code
  localparam int CODE_W = 4;

  // Thermometer tap selects per delay buffer
  // One select per nonzero code value
  localparam int TAP_W = (1 << CODE_W) - 1;

  // Full length of the serial configuration chain
  localparam int CHAIN_W = N_CDA * CODE_W;

  // ==================================================
  // Configuration types
  // ==================================================

  // Delay code of a single CDA, 0 means no extra taps
  typedef logic [CODE_W-1:0] cda_code_t;

  // One whole-region configuration word
  // raw is the serial view, bit 0 leaves the loader first
  // code is the per-CDA view, element 0 sits in the top bits
  // After a full shift the first bit sent ends at the far end of the chain,
  // which is why CDA 0 lines up with the most significant nibble
  typedef union packed
  {
    logic [CHAIN_W-1:0] raw;
    cda_code_t [0:N_CDA-1] code;
  } cda_cfg_u;

endpackage

// File: src/gclk_prog_delay_buf.sv
module gclk_prog_delay_buf #(
  parameter int BASE_DELAY = 2,
  parameter int TAP_DELAY  = 1
) (
  input  logic                      clk,
  input  logic [cda_pkg::TAP_W-1:0] rsel,
  output logic                      clkout
);

  import cda_pkg::*;

  // Behavioural stand-in for a programmable delay clock cell
  // Each asserted select adds one tap to the insertion delay

  // Number of taps currently switched in
  int unsigned tap_cnt;

  // Total delay applied to the next clock edge
  int unsigned edge_dly;

  // ==================================================
  // Tap count
  // ==================================================

  // Count asserted selects
  // A proper thermometer code gives the same result as the code itself
  always_comb
  begin
    tap_cnt = 0;
    for (int i = 0; i < TAP_W; i++)
    begin
      if (rsel[i])
      begin
        tap_cnt = tap_cnt + 1;
      end
    end
  end

  // Fixed cell delay plus the selected taps
  assign edge_dly = BASE_DELAY + tap_cnt * TAP_DELAY;

  // ==================================================
  // Edge scheduling
  // ==================================================

  // Nonblocking intra-assignment delay behaves like transport delay
  // Every edge of clk is replayed, even if the next one arrives first
  // A code change only affects edges launched after it
  always @(clk)
  begin
    clkout <= #(edge_dly) clk;
  end

endmodule

// File: src/gclk_make_clk_cda.sv
module gclk_make_clk_cda #(
  parameter int BASE_DELAY = 2,
  parameter int TAP_DELAY  = 1
) (
  // Clock path
  input  logic clk_in,
  output logic clk_out,

  // LCP configuration chain
  input  logic CkLcpXPNB,
  input  logic reset_b,
  input  logic CdaDatIn,
  output logic CdaDatOut
);

  import cda_pkg::*;

  // One clock delay adjuster
  // Its 4-bit code is a slice of the region's serial LCP chain

  // Delay code held in the LCP slice
  cda_code_t lcp_code;

  // Thermometer tap selects into the delay buffer
  logic [TAP_W-1:0] tap_sel;

  // ==================================================
  // LCP shift slice
  // ==================================================

  // Serial data enters at the top bit and leaves from bit 0
  // Four shifts move a full code through this slice
  always_ff @(posedge CkLcpXPNB or negedge reset_b)
  begin
    if (!reset_b)
    begin
      lcp_code <= '0;
    end
    else
    begin
      lcp_code <= {CdaDatIn, lcp_code[CODE_W-1:1]};
    end
  end

  // B-latch on the chain output
  // Open while the LCP clock is low, closed across the rising edge
  // The next slice samples a value that cannot move under it
  always_latch
  begin
    if (!CkLcpXPNB)
    begin
      CdaDatOut <= lcp_code[0];
    end
  end

  // ==================================================
  // Thermometer decode
  // ==================================================

  // Code n turns on the n lowest selects
  // Code 0 leaves only the base cell delay
  always_comb
  begin
    for (int i = 0; i < TAP_W; i++)
    begin
      tap_sel[i] = (lcp_code > CODE_W'(i));
    end
  end

  // ==================================================
  // Delay element
  // ==================================================

  // Regional clock copy, delayed by the decoded tap count
  gclk_prog_delay_buf #(
    .BASE_DELAY (BASE_DELAY),
    .TAP_DELAY  (TAP_DELAY)
  ) i_gclk_prog_delay_buf (
    .clk    (clk_in),
    .rsel   (tap_sel),
    .clkout (clk_out)
  );

endmodule

// File: src/lcp_chain_loader.sv
module lcp_chain_loader #(
  parameter int CFG_DEPTH = 2
) (
  input  logic              CkLcpXPNB,
  input  logic              reset_b,

  // Host write side, credit based
  input  logic              cfg_valid,
  input  cda_pkg::cda_cfg_u cfg_word,
  output logic              cfg_credit,

  // Readback of the configuration shifted out
  output logic              rb_valid,
  output cda_pkg::cda_cfg_u rb_word,

  // Serial chain
  output logic              lcp_clk,
  output logic              chain_in,
  input  logic              chain_out
);

  import cda_pkg::*;

  // Queue pointer and occupancy widths
  // Keep the pointer at least one bit wide for a single entry queue
  localparam int PTR_W = (CFG_DEPTH > 1) ? $clog2(CFG_DEPTH) : 1;
  localparam int CNT_W = $clog2(CFG_DEPTH + 1);

  // Bit counter width for one chain pass
  localparam int BIT_W = (CHAIN_W > 1) ? $clog2(CHAIN_W) : 1;

  // Queue storage and control
  cda_cfg_u         cfg_mem [CFG_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] q_count;
  logic             q_empty;
  logic             push;
  logic             pop;

  // Serializer state
  logic             shifting;
  logic [BIT_W-1:0] bit_cnt;
  logic             last_bit;
  logic [CHAIN_W-1:0] shift_q;

  // Readback capture
  logic [CHAIN_W-1:0] cap_q;

  // Clock gate enable, latched in the low phase
  logic             gate_en_lat;

  // Wrapping increment for queue pointers
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(CFG_DEPTH - 1))
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ==================================================
  // Config queue
  // ==================================================

  // Host holds off on its own when out of credit
  // Credits never exceed the queue depth, so a push always has room
  assign push    = cfg_valid;
  assign q_empty = (q_count == '0);

  // Next word starts as soon as the serializer is free
  assign pop = !shifting && !q_empty;

  always_ff @(posedge CkLcpXPNB or negedge reset_b)
  begin
    if (!reset_b)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop)
      begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Occupancy only moves when exactly one side is active
      case ({push, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end
  end

  // Queue entries
  always_ff @(posedge CkLcpXPNB)
  begin
    if (push)
    begin
      cfg_mem[wr_ptr] <= cfg_word;
    end
  end

  // ==================================================
  // Serializer control
  // ==================================================

  // Final shift of the current word
  assign last_bit = (bit_cnt == BIT_W'(CHAIN_W - 1));

  // Credit goes back in the cycle the entry leaves the queue
  // Readback pulses right after the last shift edge
  always_ff @(posedge CkLcpXPNB or negedge reset_b)
  begin
    if (!reset_b)
    begin
      shifting   <= 1'b0;
      bit_cnt    <= '0;
      cfg_credit <= 1'b0;
      rb_valid   <= 1'b0;
    end
    else
    begin
      cfg_credit <= pop;
      rb_valid   <= shifting && last_bit;
      if (pop)
      begin
        shifting <= 1'b1;
        bit_cnt  <= '0;
      end
      else if (shifting)
      begin
        bit_cnt <= bit_cnt + 1'b1;
        if (last_bit)
        begin
          shifting <= 1'b0;
        end
      end
    end
  end

  // Outgoing data, LSB first, zero fill behind it
  always_ff @(posedge CkLcpXPNB)
  begin
    if (pop)
    begin
      shift_q <= cfg_mem[rd_ptr].raw;
    end
    else if (shifting)
    begin
      shift_q <= {1'b0, shift_q[CHAIN_W-1:1]};
    end
  end

  // Chain input launched in the low phase, same as a CDA output
  // Stable across every gated rising edge
  always_latch
  begin
    if (!CkLcpXPNB)
    begin
      chain_in <= shift_q[0];
    end
  end

  // ==================================================
  // Readback capture
  // ==================================================

  // Old chain contents arrive in raw order
  // Entering from the top leaves the first bit at bit 0 after a full pass
  always_ff @(posedge CkLcpXPNB)
  begin
    if (shifting)
    begin
      cap_q <= {chain_out, cap_q[CHAIN_W-1:1]};
    end
  end

  assign rb_word.raw = cap_q;

  // ==================================================
  // LCP clock gate
  // ==================================================

  // Enable passes only while the clock is low
  // Held at zero in reset so the chain clock stays quiet
  always_latch
  begin
    if (!reset_b)
    begin
      gate_en_lat <= 1'b0;
    end
    else if (!CkLcpXPNB)
    begin
      gate_en_lat <= shifting;
    end
  end

  // One rising edge per shift cycle, none otherwise
  assign lcp_clk = CkLcpXPNB & gate_en_lat;

endmodule

// File: src/cda_region_top.sv
module cda_region_top #(
  parameter int CFG_DEPTH  = 2,
  parameter int BASE_DELAY = 2,
  parameter int TAP_DELAY  = 1
) (
  input  logic                      CkLcpXPNB,
  input  logic                      reset_b,
  input  logic                      gclk_root,

  // Host configuration port
  input  logic                      cfg_valid,
  input  cda_pkg::cda_cfg_u         cfg_word,
  output logic                      cfg_credit,

  // Readback port, no back-pressure
  output logic                      rb_valid,
  output cda_pkg::cda_cfg_u         rb_word,

  // Regional clock copies
  output logic [cda_pkg::N_CDA-1:0] clk_out
);

  import cda_pkg::*;

  // Gated LCP clock shared by every CDA slice
  logic lcp_clk;

  // Daisy chain taps
  // chain[0] leaves the loader, chain[N_CDA] comes back to it
  logic [N_CDA:0] chain;

  // ==================================================
  // Chain loader
  // ==================================================

  lcp_chain_loader #(
    .CFG_DEPTH (CFG_DEPTH)
  ) i_lcp_chain_loader (
    .CkLcpXPNB  (CkLcpXPNB),
    .reset_b    (reset_b),
    .cfg_valid  (cfg_valid),
    .cfg_word   (cfg_word),
    .cfg_credit (cfg_credit),
    .rb_valid   (rb_valid),
    .rb_word    (rb_word),
    .lcp_clk    (lcp_clk),
    .chain_in   (chain[0]),
    .chain_out  (chain[N_CDA])
  );

  // ==================================================
  // Delay adjusters
  // ==================================================

  // CDA i sits between chain[i] and chain[i+1]
  for (genvar i = 0; i < N_CDA; i++)
  begin : g_cda
    gclk_make_clk_cda #(
      .BASE_DELAY (BASE_DELAY),
      .TAP_DELAY  (TAP_DELAY)
    ) i_gclk_make_clk_cda (
      .clk_in    (gclk_root),
      .clk_out   (clk_out[i]),
      .CkLcpXPNB (lcp_clk),
      .reset_b   (reset_b),
      .CdaDatIn  (chain[i]),
      .CdaDatOut (chain[i+1])
    );
  end

endmodule

// File: testbench/cda_region_checker.sv
module cda_region_checker #(
  parameter int CFG_DEPTH = 2
) (
  input logic CkLcpXPNB,
  input logic reset_b,
  input logic cfg_valid,
  input logic cfg_credit,
  input logic rb_valid,
  input logic gate_en,
  input logic shifting,
  input logic chain_in
);

  // Credits still held by the host
  // Tracked at the loader pins
  int credit_cnt;

  // ==================================================
  // Credit bookkeeping
  // ==================================================

  // Host starts with one credit per queue entry
  // A returned credit and a spent one may meet in the same cycle
  always_ff @(posedge CkLcpXPNB or negedge reset_b)
  begin
    if (!reset_b)
    begin
      credit_cnt <= CFG_DEPTH;
    end
    else
    begin
      credit_cnt <= credit_cnt + int'(cfg_credit) - int'(cfg_valid);
    end
  end

  // ==================================================
  // Protocol properties
  // ==================================================

  // Writes only while a credit is held
  a_credit_held: assert property (@(posedge CkLcpXPNB) disable iff (!reset_b)
    cfg_valid |-> (credit_cnt + int'(cfg_credit)) > 0)
    else $error("cfg_valid asserted with no credit left");

  // Readback is a single-cycle pulse
  a_rb_pulse: assert property (@(posedge CkLcpXPNB) disable iff (!reset_b)
    rb_valid |=> !rb_valid)
    else $error("rb_valid held longer than one cycle");

  // Gate closed for the readback cycle, so lcp_clk gives no edge there
  a_rb_quiet: assert property (@(posedge CkLcpXPNB) disable iff (!reset_b)
    rb_valid |-> !gate_en)
    else $error("lcp_clk enabled while rb_valid is high");

  // Serial data known on every shift edge
  a_chain_known: assert property (@(posedge CkLcpXPNB) disable iff (!reset_b)
    shifting |-> !$isunknown(chain_in))
    else $error("chain_in unknown during shifting");

endmodule

// File: testbench/cda_region_tb.sv
module cda_region_tb;

  import cda_pkg::*;

  // DUT configuration
  localparam int CFG_DEPTH  = 2;
  localparam int BASE_DELAY = 2;
  localparam int TAP_DELAY  = 1;

  // Words per test phase
  localparam int N_SINGLE = 6;
  localparam int N_B2B    = 4;
  localparam int N_BURST  = 24;
  localparam int N_WORDS  = 1 + N_SINGLE + N_B2B + N_BURST;

  // Four times the serial time of every word
  localparam int WATCHDOG_TIME = N_WORDS * (CHAIN_W + 2) * 20 * 4;

  logic              CkLcpXPNB;
  logic              reset_b;
  logic              gclk_root;
  logic              cfg_valid;
  cda_cfg_u          cfg_word;
  logic              cfg_credit;
  logic              rb_valid;
  cda_cfg_u          rb_word;
  logic [N_CDA-1:0]  clk_out;

  // Host and model state
  cda_cfg_u last_cfg;
  cda_cfg_u exp_rb_q[$];
  cda_cfg_u rb_expected;
  int       edge_cnt;
  int       credit_seen;
  int       sent_cnt;
  int       rb_cnt;
  int       accept_edge;
  int       rb_edge;

  cda_region_top #(
    .CFG_DEPTH  (CFG_DEPTH),
    .BASE_DELAY (BASE_DELAY),
    .TAP_DELAY  (TAP_DELAY)
  ) i_cda_region_top (
    .CkLcpXPNB  (CkLcpXPNB),
    .reset_b    (reset_b),
    .gclk_root  (gclk_root),
    .cfg_valid  (cfg_valid),
    .cfg_word   (cfg_word),
    .cfg_credit (cfg_credit),
    .rb_valid   (rb_valid),
    .rb_word    (rb_word),
    .clk_out    (clk_out)
  );

  // Protocol assertions on the loader
  bind lcp_chain_loader cda_region_checker #(
    .CFG_DEPTH (CFG_DEPTH)
  ) i_cda_region_checker (
    .CkLcpXPNB  (CkLcpXPNB),
    .reset_b    (reset_b),
    .cfg_valid  (cfg_valid),
    .cfg_credit (cfg_credit),
    .rb_valid   (rb_valid),
    .gate_en    (gate_en_lat),
    .shifting   (shifting),
    .chain_in   (chain_in)
  );

  // ==================================================
  // Clocks and watchdog
  // ==================================================

  initial
  begin
    CkLcpXPNB = 1'b0;
    forever #10 CkLcpXPNB = ~CkLcpXPNB;
  end

  // Root clock with a half period above the largest delay
  initial
  begin
    gclk_root = 1'b0;
    forever #20 gclk_root = ~gclk_root;
  end

  initial
  begin
    #(WATCHDOG_TIME);
    abort_run("Watchdog expired before all words were loaded");
  end

  // ==================================================
  // Reference model and compare tasks
  // ==================================================

  // Expected root-to-output delay for one code
  function automatic int ref_delay(input cda_code_t code);
    return BASE_DELAY + int'(code) * TAP_DELAY;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic compare_cfg(input string name, input cda_cfg_u expected,
                             input cda_cfg_u actual);
    if (actual !== expected)
    begin
      abort_run($sformatf("MISMATCH %s expected 0x%h got 0x%h",
                          name, expected.raw, actual.raw));
    end
  endtask

  task automatic compare_delay(input int idx, input cda_code_t code, input int measured);
    int expected;
    expected = ref_delay(code);
    if (measured != expected)
    begin
      abort_run($sformatf("MISMATCH clk_out[%0d] delay for code 0x%h expected 0x%h got 0x%h",
                          idx, code, expected, measured));
    end
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    if (actual != expected)
    begin
      abort_run($sformatf("MISMATCH %s expected 0x%h got 0x%h", name, expected, actual));
    end
  endtask

  // ==================================================
  // Monitors
  // ==================================================

  // Posedge count that is read at falling edges only
  always @(posedge CkLcpXPNB)
  begin
    edge_cnt <= edge_cnt + 1;
    if (reset_b && cfg_credit)
    begin
      credit_seen <= credit_seen + 1;
    end
  end

  // Readback compare sampled mid-cycle
  always @(negedge CkLcpXPNB)
  begin
    if (reset_b && rb_valid)
    begin
      rb_cnt  = rb_cnt + 1;
      rb_edge = edge_cnt + 1;
      if (exp_rb_q.size() == 0)
      begin
        abort_run("rb_valid pulsed with no configuration word outstanding");
      end
      else
      begin
        rb_expected = exp_rb_q.pop_front();
        compare_cfg("rb_word", rb_expected, rb_word);
      end
    end
  end

  // ==================================================
  // Host tasks
  // ==================================================

  // Called at a falling edge and returns at the next one
  task automatic send_word(input cda_cfg_u w);
    while (CFG_DEPTH + credit_seen - sent_cnt <= 0)
    begin
      @(negedge CkLcpXPNB);
    end
    cfg_valid   = 1'b1;
    cfg_word    = w;
    accept_edge = edge_cnt + 1;
    sent_cnt    = sent_cnt + 1;
    // Chain currently holds the previous word
    exp_rb_q.push_back(last_cfg);
    last_cfg = w;
    @(negedge CkLcpXPNB);
    cfg_valid = 1'b0;
  endtask

  // Every word sent has come back
  task automatic wait_idle();
    while (rb_cnt != sent_cnt)
    begin
      @(negedge CkLcpXPNB);
    end
  endtask

  // Root rise to each output rise for all CDAs in one root cycle
  task automatic check_delays();
    time              t0;
    int               dly [N_CDA];
    logic [N_CDA-1:0] seen;
    @(posedge gclk_root);
    t0   = $time;
    seen = '0;
    while (seen != '1)
    begin
      @(clk_out);
      for (int i = 0; i < N_CDA; i++)
      begin
        if (clk_out[i] && !seen[i])
        begin
          seen[i] = 1'b1;
          dly[i]  = int'($time - t0);
        end
      end
    end
    for (int i = 0; i < N_CDA; i++)
    begin
      compare_delay(i, last_cfg.code[i], dly[i]);
    end
    @(negedge CkLcpXPNB);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial
  begin
    cda_cfg_u w;
    int       gap;
    void'($urandom(32'h46fc));
    reset_b     = 1'b0;
    cfg_valid   = 1'b0;
    cfg_word    = '0;
    last_cfg    = '0;
    edge_cnt    = 0;
    credit_seen = 0;
    sent_cnt    = 0;
    rb_cnt      = 0;
    repeat (5) @(negedge CkLcpXPNB);
    reset_b = 1'b1;

    // Idle after reset with base delay only
    repeat (10) @(negedge CkLcpXPNB);
    compare_count("cfg_credit pulses", 0, credit_seen);
    compare_count("rb_valid pulses", 0, rb_cnt);
    check_delays();

    // Single word from idle with fixed latency and zero readback
    w.raw = CHAIN_W'($urandom());
    send_word(w);
    wait_idle();
    compare_count("rb_valid latency", CHAIN_W + 2, rb_edge - accept_edge);
    check_delays();

    // Extreme, alternating and random codes
    for (int n = 0; n < N_SINGLE; n++)
    begin
      case (n)
        0: w.raw = '1;
        1: w.raw = '0;
        2:
        begin
          for (int i = 0; i < N_CDA; i++)
          begin
            w.code[i] = (i % 2 == 0) ? 4'hF : 4'h0;
          end
        end
        default: w.raw = CHAIN_W'($urandom());
      endcase
      send_word(w);
      wait_idle();
      check_delays();
    end

    // Back-to-back words queued behind the serializer
    for (int n = 0; n < N_B2B; n++)
    begin
      w.raw = CHAIN_W'($urandom());
      send_word(w);
    end
    wait_idle();
    check_delays();

    // Random bursts paced by credits only
    for (int n = 0; n < N_BURST; n++)
    begin
      gap = int'($urandom_range(2, 0));
      repeat (gap) @(negedge CkLcpXPNB);
      w.raw = CHAIN_W'($urandom());
      send_word(w);
    end
    wait_idle();
    check_delays();

    // One credit back for every word written
    if (credit_seen == N_WORDS)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
    begin
      abort_run($sformatf("MISMATCH cfg_credit pulses expected 0x%h got 0x%h",
                          N_WORDS, credit_seen));
    end
  end

endmodule

// File: cda_region.f
src/cda_pkg.sv
src/gclk_prog_delay_buf.sv
src/gclk_make_clk_cda.sv
src/lcp_chain_loader.sv
src/cda_region_top.sv
testbench/cda_region_checker.sv
testbench/cda_region_tb.sv

// File: Makefile
SIM  := obj_dir/Vcda_region_tb
SRCS := $(shell cat cda_region.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): cda_region.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module cda_region_tb -f cda_region.f

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
